// ==== hdl/miriscv_pkg.sv ====
package miriscv_pkg;

  // access size, coded as the RISC-V load funct3
  // bit 2 set marks the unsigned variants
  typedef enum logic [2:0] {
    LDST_B  = 3'd0,
    LDST_H  = 3'd1,
    LDST_W  = 3'd2,
    LDST_BU = 3'd4,
    LDST_HU = 3'd5
  } ldst_size_e;

  // request from the core
  typedef struct packed {
    // request level, held until completion
    logic       req;
    // 1 for a store
    logic       we;
    ldst_size_e size;
    // byte address
    logic [31:0] addr;
    // store data, low bits used for narrow stores
    logic [31:0] wdata;
  } lsu_req_t;

  // request from the lsu to the data memory
  typedef struct packed {
    logic        req;
    logic        we;
    // one bit per byte lane
    logic [3:0]  be;
    // word aligned, low two bits are zero
    logic [31:0] addr;
    // store data already replicated over the lanes
    logic [31:0] wdata;
  } mem_req_t;

  // one memory word, seen as bytes or as halfwords
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } mem_word_u;

endpackage

// ==== hdl/miriscv_ram_lane.sv ====
`timescale 1ns/100ps

module miriscv_ram_lane #(
  parameter  int MEM_WORDS = 64,
  localparam int IDX_W     = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1
) (
  input  logic             clk_i,
  // request, write flag and byte enable already merged
  input  logic             we_i,
  // word index
  input  logic [IDX_W-1:0] addr_i,
  input  logic [7:0]       wdata_i,
  output logic [7:0]       rdata_o
);

  // one byte of every word
  logic [7:0] mem_q [MEM_WORDS];

  // write lands on the edge, read data follows a cycle later
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    rdata_o <= mem_q[addr_i];
  end

endmodule

// ==== hdl/miriscv_data_mem.sv ====
`timescale 1ns/100ps

module miriscv_data_mem #(
  parameter int MEM_WORDS = 64
) (
  input  logic                   clk_i,
  input  miriscv_pkg::mem_req_t  mem_req_i,
  output miriscv_pkg::mem_word_u mem_rdata_o
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [IDX_W-1:0] word_idx;
  wire  [3:0][7:0]  lane_rdata;

  // word index from the byte address
  assign word_idx = mem_req_i.addr[IDX_W+1:2];

  genvar lane;
  for (lane = 0; lane < 4; lane++) begin : g_lane
    logic lane_we;

    // only the enabled byte lanes write
    assign lane_we = mem_req_i.req & mem_req_i.we & mem_req_i.be[lane];

    miriscv_ram_lane #(
      .MEM_WORDS (MEM_WORDS)
    ) ram_lane_inst (
      .clk_i   (clk_i),
      .we_i    (lane_we),
      .addr_i  (word_idx),
      .wdata_i (mem_req_i.wdata[8*lane +: 8]),
      .rdata_o (lane_rdata[lane])
    );
  end

  // lane outputs gathered into the byte view
  assign mem_rdata_o.bytes = lane_rdata;

  // upper address bits are dropped, so they must stay inside the depth
  a_addr_in_range: assert property (
    @(posedge clk_i)
    mem_req_i.req |-> (mem_req_i.addr[31:2] < MEM_WORDS)
  );

endmodule

// ==== hdl/miriscv_lsu.sv ====
`timescale 1ns/100ps

module miriscv_lsu (
  input  logic                  clk_i,
  input  logic                  arstn_i,

  // core side
  input  miriscv_pkg::lsu_req_t lsu_req_i,
  output logic                  lsu_stall_req_o,
  output logic [31:0]           lsu_data_o,

  // memory side
  output miriscv_pkg::mem_req_t mem_req_o,
  input  miriscv_pkg::mem_word_u mem_rdata_i
);

  import miriscv_pkg::*;

  logic [1:0]  byte_offset;
  logic        load_signed;
  logic        done_q;
  logic [3:0]  be;
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  mem_word_u   wdata_rep;

  assign byte_offset = lsu_req_i.addr[1:0];

  // funct3 bit 2 clear means sign extension
  assign load_signed = ~lsu_req_i.size[2];

  // done is set after the stall cycle and cleared after completion
  // a request held high then restarts with a fresh stall cycle
  always_ff @(posedge clk_i) begin
    if (arstn_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= lsu_req_i.req & ~done_q;
    end
  end

  assign lsu_stall_req_o = lsu_req_i.req & ~done_q;

  // byte enables from size and offset
  always_comb begin
    unique case (lsu_req_i.size)
      LDST_B, LDST_BU: be = 4'b0001 << byte_offset;
      LDST_H, LDST_HU: be = 4'b0011 << {byte_offset[1], 1'b0};
      LDST_W:          be = 4'b1111;
      default:         be = 4'b0000;
    endcase
  end

  // store data replicated so every lane sees its part
  always_comb begin
    unique case (lsu_req_i.size)
      LDST_B, LDST_BU: wdata_rep.bytes  = {4{lsu_req_i.wdata[7:0]}};
      LDST_H, LDST_HU: wdata_rep.halves = {2{lsu_req_i.wdata[15:0]}};
      default:         wdata_rep.bytes  = lsu_req_i.wdata;
    endcase
  end

  // pick the addressed byte and halfword out of the read word
  assign byte_sel = mem_rdata_i.bytes[byte_offset];
  assign half_sel = mem_rdata_i.halves[byte_offset[1]];

  // load data extended as the size asks
  always_comb begin
    unique case (lsu_req_i.size)
      LDST_B, LDST_BU: begin
        lsu_data_o = {{24{load_signed & byte_sel[7]}}, byte_sel};
      end
      LDST_H, LDST_HU: begin
        lsu_data_o = {{16{load_signed & half_sel[15]}}, half_sel};
      end
      LDST_W: begin
        lsu_data_o = mem_rdata_i.bytes;
      end
      default: begin
        lsu_data_o = 32'd0;
      end
    endcase
  end

  assign mem_req_o.req   = lsu_req_i.req;
  assign mem_req_o.we    = lsu_req_i.we;
  assign mem_req_o.be    = be;
  assign mem_req_o.addr  = {lsu_req_i.addr[31:2], 2'b00};
  assign mem_req_o.wdata = wdata_rep.bytes;

  // misaligned accesses are not handled here
  a_half_aligned: assert property (
    @(posedge clk_i) disable iff (arstn_i)
    lsu_req_i.req && (lsu_req_i.size inside {LDST_H, LDST_HU}) |-> !byte_offset[0]
  );

  a_word_aligned: assert property (
    @(posedge clk_i) disable iff (arstn_i)
    lsu_req_i.req && (lsu_req_i.size == LDST_W) |-> (byte_offset == 2'b00)
  );

  a_size_known: assert property (
    @(posedge clk_i) disable iff (arstn_i)
    lsu_req_i.req |-> (lsu_req_i.size inside {LDST_B, LDST_H, LDST_W, LDST_BU, LDST_HU})
  );

endmodule

// ==== hdl/miriscv_lsu_top.sv ====
`timescale 1ns/100ps

module miriscv_lsu_top #(
  parameter int MEM_WORDS = 64
) (
  input  logic                  clk_i,
  input  logic                  arstn_i,
  input  miriscv_pkg::lsu_req_t lsu_req_i,
  output logic                  lsu_stall_req_o,
  output logic [31:0]           lsu_data_o
);

  import miriscv_pkg::*;

  // lsu to memory
  mem_req_t  mem_req;
  // read word back to the lsu
  mem_word_u mem_rdata;

  miriscv_lsu lsu_inst (
    .clk_i           (clk_i),
    .arstn_i         (arstn_i),
    .lsu_req_i       (lsu_req_i),
    .lsu_stall_req_o (lsu_stall_req_o),
    .lsu_data_o      (lsu_data_o),
    .mem_req_o       (mem_req),
    .mem_rdata_i     (mem_rdata)
  );

  miriscv_data_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) data_mem_inst (
    .clk_i       (clk_i),
    .mem_req_i   (mem_req),
    .mem_rdata_o (mem_rdata)
  );

endmodule

// ==== tests/lsu_checker.sv ====
`timescale 1ns/100ps

module lsu_checker #(
  parameter int MEM_WORDS = 64
) (
  input  logic                  clk_i,
  input  logic                  arstn_i,
  input  miriscv_pkg::lsu_req_t lsu_req_i,
  input  logic                  stall_i,
  input  logic [31:0]           data_i,
  output int                    error_count_o,
  output int                    load_count_o
);

  import miriscv_pkg::*;

  // byte-addressed reference memory, little endian
  logic [7:0]  model_mem [MEM_WORDS*4];
  // high in the cycle after a stall cycle
  logic        done_q;
  logic        exp_stall;
  logic [31:0] exp_data;
  int          byte_idx;

  function automatic logic [31:0] expected_load(input ldst_size_e size, input int idx);
    logic [31:0] result;
    case (size)
      LDST_B:  result = {{24{model_mem[idx][7]}}, model_mem[idx]};
      LDST_BU: result = {24'd0, model_mem[idx]};
      LDST_H:  result = {{16{model_mem[idx+1][7]}}, model_mem[idx+1], model_mem[idx]};
      LDST_HU: result = {16'd0, model_mem[idx+1], model_mem[idx]};
      LDST_W: begin
        result = {model_mem[idx+3], model_mem[idx+2], model_mem[idx+1], model_mem[idx]};
      end
      default: result = 'x;
    endcase
    return result;
  endfunction

  task automatic store_model(input ldst_size_e size, input int idx, input logic [31:0] wdata);
    case (size)
      LDST_B, LDST_BU: begin
        model_mem[idx] = wdata[7:0];
      end
      LDST_H, LDST_HU: begin
        model_mem[idx]   = wdata[7:0];
        model_mem[idx+1] = wdata[15:8];
      end
      default: begin
        for (int i = 0; i < 4; i++) begin
          model_mem[idx+i] = wdata[8*i +: 8];
        end
      end
    endcase
  endtask

  always @(posedge clk_i) begin
    if (arstn_i) begin
      done_q        <= 1'b0;
      error_count_o =  0;
      load_count_o  =  0;
    end else begin
      // one stall cycle, then the completion cycle
      exp_stall = lsu_req_i.req & ~done_q;
      if (stall_i !== exp_stall) begin
        $display("FAIL lsu_stall_req_o at %0t: expected %h actual %h",
                 $time, exp_stall, stall_i);
        error_count_o = error_count_o + 1;
      end
      if (lsu_req_i.req && !exp_stall) begin
        byte_idx = lsu_req_i.addr;
        if (lsu_req_i.we) begin
          store_model(lsu_req_i.size, byte_idx, lsu_req_i.wdata);
        end else begin
          exp_data     = expected_load(lsu_req_i.size, byte_idx);
          load_count_o = load_count_o + 1;
          if (data_i !== exp_data) begin
            $display("FAIL lsu_data_o addr %h size %0d: expected %h actual %h",
                     lsu_req_i.addr, lsu_req_i.size, exp_data, data_i);
            error_count_o = error_count_o + 1;
          end
        end
      end
      done_q <= exp_stall;
    end
  end

endmodule

// ==== tests/tb_miriscv_lsu.sv ====
`timescale 1ns/100ps

module tb_miriscv_lsu #(
  parameter int SEED = 42
);

  import miriscv_pkg::*;

  localparam int MEM_WORDS     = 64;
  // falling edges a request may stay stalled
  localparam int STALL_TIMEOUT = 16;

  logic        clk;
  logic        arstn;
  lsu_req_t    lsu_req;
  logic        lsu_stall;
  logic [31:0] lsu_data;

  int          checker_errors;
  int          loads_checked;
  int          timeouts;
  int          tests_run;
  int          tests_failed;
  int          errors_at_start;
  bit          hung;

  always #2 clk = ~clk;

  miriscv_lsu_top #(
    .MEM_WORDS (MEM_WORDS)
  ) miriscv_lsu_top_inst (
    .clk_i           (clk),
    .arstn_i         (arstn),
    .lsu_req_i       (lsu_req),
    .lsu_stall_req_o (lsu_stall),
    .lsu_data_o      (lsu_data)
  );

  lsu_checker #(
    .MEM_WORDS (MEM_WORDS)
  ) checker_inst (
    .clk_i         (clk),
    .arstn_i       (arstn),
    .lsu_req_i     (lsu_req),
    .stall_i       (lsu_stall),
    .data_i        (lsu_data),
    .error_count_o (checker_errors),
    .load_count_o  (loads_checked)
  );

  function automatic int total_errors();
    return checker_errors + timeouts;
  endfunction

  task automatic finish_test(input string name);
    int errs;
    errs = total_errors() - errors_at_start;
    tests_run++;
    if (errs == 0) begin
      $display("test %-14s PASS", name);
    end else begin
      tests_failed++;
      $display("test %-14s FAIL with %0d errors", name, errs);
    end
    errors_at_start = total_errors();
  endtask

  task automatic go_idle(input int cycles);
    lsu_req.req = 1'b0;
    repeat (cycles) @(negedge clk);
  endtask

  // called on a falling edge and returns on the falling edge after completion
  task automatic run_access(input logic we, input ldst_size_e size,
                            input logic [31:0] addr, input logic [31:0] wdata);
    int waited;
    if (hung) begin
      return;
    end
    lsu_req.req   = 1'b1;
    lsu_req.we    = we;
    lsu_req.size  = size;
    lsu_req.addr  = addr;
    lsu_req.wdata = wdata;
    waited = 0;
    @(negedge clk);
    while (lsu_stall !== 1'b0 && waited < STALL_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (lsu_stall !== 1'b0) begin
      $display("request never completed: address %h still stalled after %0d cycles",
               addr, waited);
      timeouts++;
      hung        = 1'b1;
      lsu_req.req = 1'b0;
    end else begin
      // completion edge comes before the next falling edge
      @(negedge clk);
    end
  endtask

  task automatic word_fill();
    for (int i = 0; i < MEM_WORDS; i++) begin
      run_access(1'b1, LDST_W, i * 4, $urandom());
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      run_access(1'b0, LDST_W, i * 4, $urandom());
    end
    go_idle(2);
  endtask

  task automatic back_to_back();
    for (int i = 0; i < 8; i++) begin
      run_access(1'b1, LDST_W, i * 4, $urandom());
      run_access(1'b0, LDST_W, i * 4, 32'd0);
    end
    // same pairs with gaps
    for (int i = 0; i < 8; i++) begin
      run_access(1'b1, LDST_W, i * 4, $urandom());
      go_idle(1);
      run_access(1'b0, LDST_W, i * 4, 32'd0);
      go_idle(1);
    end
  endtask

  task automatic byte_lanes();
    logic [31:0] wdata;
    for (int w = 0; w < 8; w++) begin
      for (int off = 0; off < 4; off++) begin
        wdata    = $urandom();
        // alternate the sign bit
        wdata[7] = off[0] ^ w[0];
        run_access(1'b1, LDST_B, w * 4 + off, wdata);
        run_access(1'b0, LDST_W, w * 4, 32'd0);
        run_access(1'b0, LDST_B, w * 4 + off, 32'd0);
        run_access(1'b0, LDST_BU, w * 4 + off, 32'd0);
      end
    end
    go_idle(2);
  endtask

  task automatic halfword_lanes();
    logic [31:0] wdata;
    for (int w = 8; w < 16; w++) begin
      for (int off = 0; off < 4; off += 2) begin
        wdata     = $urandom();
        wdata[15] = off[1] ^ w[0];
        run_access(1'b1, LDST_H, w * 4 + off, wdata);
        run_access(1'b0, LDST_W, w * 4, 32'd0);
        run_access(1'b0, LDST_H, w * 4 + off, 32'd0);
        run_access(1'b0, LDST_HU, w * 4 + off, 32'd0);
      end
    end
    go_idle(2);
  endtask

  task automatic random_mix(input int count);
    logic       we;
    ldst_size_e size;
    int         word;
    int         off;
    for (int n = 0; n < count; n++) begin
      we = ($urandom_range(1) == 1);
      // stores only use the B, H and W codes
      case ($urandom_range(we ? 2 : 4))
        0:       size = LDST_B;
        1:       size = LDST_H;
        2:       size = LDST_W;
        3:       size = LDST_BU;
        default: size = LDST_HU;
      endcase
      word = $urandom_range(MEM_WORDS - 1);
      case (size)
        LDST_B, LDST_BU: off = $urandom_range(3);
        LDST_H, LDST_HU: off = 2 * $urandom_range(1);
        default:         off = 0;
      endcase
      run_access(we, size, word * 4 + off, $urandom());
      if ($urandom_range(7) == 0) begin
        go_idle(1);
      end
    end
    go_idle(2);
  endtask

  initial begin
    void'($urandom(SEED));
    clk             = 1'b0;
    arstn           = 1'b1;
    lsu_req         = '0;
    hung            = 1'b0;
    timeouts        = 0;
    tests_run       = 0;
    tests_failed    = 0;
    repeat (16) @(negedge clk);
    arstn           = 1'b0;
    errors_at_start = total_errors();
    go_idle(12);
    finish_test("idle");
    word_fill();
    finish_test("word_fill");
    back_to_back();
    finish_test("back_to_back");
    byte_lanes();
    finish_test("byte_lanes");
    halfword_lanes();
    finish_test("halfword_lanes");
    random_mix(2000);
    finish_test("random_mix");
    if (loads_checked == 0) begin
      $display("no load was compared by the checker");
    end
    $display("tests %0d, failed %0d, loads checked %0d, errors %0d, timeouts %0d",
             tests_run, tests_failed, loads_checked, checker_errors, timeouts);
    if (tests_failed == 0 && total_errors() == 0 && !hung && loads_checked > 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
hdl/miriscv_pkg.sv
hdl/miriscv_ram_lane.sv
hdl/miriscv_data_mem.sv
hdl/miriscv_lsu.sv
hdl/miriscv_lsu_top.sv
tests/lsu_checker.sv
tests/tb_miriscv_lsu.sv

// ==== Makefile ====
# Verilator build and run of the LSU testbench

VERILATOR ?= verilator
TOP       ?= tb_miriscv_lsu
SEED      ?= 42
LOG       ?= sim.log
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  := Simulation FAILED
PASS_MSG  := Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP SEED LOG FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
	  -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "failure found in $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "no pass line in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
